// File: verilog/id_pkg.sv
`default_nettype none

package id_pkg;

    parameter int XLEN     = 32;
    parameter int REG_AW   = 5;
    parameter int NUM_REGS = 32;
    parameter logic [REG_AW-1:0] RA_REG = 5'd1;   // bl links here

    // 33 kept instructions plus invalid, so 6 bits
    typedef enum logic [5:0] {
        // register forms
        OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_NOR, OP_AND,
        OP_OR, OP_XOR, OP_SLL_W, OP_SRL_W, OP_SRA_W,
        // immediate forms
        OP_SLLI_W, OP_SRLI_W, OP_SRAI_W, OP_ADDI_W, OP_SLTI,
        OP_SLTUI, OP_ANDI, OP_ORI, OP_XORI, OP_LU12I_W, OP_PCADDU12I,
        // memory
        OP_LD_W, OP_ST_W,
        // control transfer
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_B, OP_BL, OP_JIRL,
        OP_INVALID
    } inst_op_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI     // passes src2 through
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

endpackage

`default_nettype wire

// File: verilog/id_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module id_decoder (
    input  logic [id_pkg::XLEN-1:0]   inst,
    output id_pkg::inst_op_t          op,
    output id_pkg::alu_op_t           alu_op,
    output logic                      src1_is_pc,
    output logic                      src2_is_imm,
    output logic                      gr_we,
    output id_pkg::mem_op_t           mem_op,
    output logic [id_pkg::XLEN-1:0]   imm,
    output logic [id_pkg::XLEN-1:0]   br_offs,
    output logic [id_pkg::REG_AW-1:0] raddr1,
    output logic [id_pkg::REG_AW-1:0] raddr2,
    output logic [id_pkg::REG_AW-1:0] dest,
    output logic                      uses_rj,
    output logic                      uses_rkd
);

    logic [id_pkg::REG_AW-1:0] rd;
    logic [id_pkg::REG_AW-1:0] rj;
    logic [id_pkg::REG_AW-1:0] rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]};   // offs[25:16] sits in the low bits

    // opcode fields 31:26, 25:22, 21:20, 19:15
    always_comb begin
        casez (inst[31:15])
            17'b000000_0000_01_00000: op = id_pkg::OP_ADD_W;
            17'b000000_0000_01_00010: op = id_pkg::OP_SUB_W;
            17'b000000_0000_01_00100: op = id_pkg::OP_SLT;
            17'b000000_0000_01_00101: op = id_pkg::OP_SLTU;
            17'b000000_0000_01_01000: op = id_pkg::OP_NOR;
            17'b000000_0000_01_01001: op = id_pkg::OP_AND;
            17'b000000_0000_01_01010: op = id_pkg::OP_OR;
            17'b000000_0000_01_01011: op = id_pkg::OP_XOR;
            17'b000000_0000_01_01110: op = id_pkg::OP_SLL_W;
            17'b000000_0000_01_01111: op = id_pkg::OP_SRL_W;
            17'b000000_0000_01_10000: op = id_pkg::OP_SRA_W;
            17'b000000_0001_00_00001: op = id_pkg::OP_SLLI_W;
            17'b000000_0001_00_01001: op = id_pkg::OP_SRLI_W;
            17'b000000_0001_00_10001: op = id_pkg::OP_SRAI_W;
            17'b000000_1000_???????:  op = id_pkg::OP_SLTI;
            17'b000000_1001_???????:  op = id_pkg::OP_SLTUI;
            17'b000000_1010_???????:  op = id_pkg::OP_ADDI_W;
            17'b000000_1101_???????:  op = id_pkg::OP_ANDI;
            17'b000000_1110_???????:  op = id_pkg::OP_ORI;
            17'b000000_1111_???????:  op = id_pkg::OP_XORI;
            17'b0001010_??????????:   op = id_pkg::OP_LU12I_W;
            17'b0001110_??????????:   op = id_pkg::OP_PCADDU12I;
            17'b001010_0010_???????:  op = id_pkg::OP_LD_W;
            17'b001010_0110_???????:  op = id_pkg::OP_ST_W;
            17'b010011_???????????:   op = id_pkg::OP_JIRL;
            17'b010100_???????????:   op = id_pkg::OP_B;
            17'b010101_???????????:   op = id_pkg::OP_BL;
            17'b010110_???????????:   op = id_pkg::OP_BEQ;
            17'b010111_???????????:   op = id_pkg::OP_BNE;
            17'b011000_???????????:   op = id_pkg::OP_BLT;
            17'b011001_???????????:   op = id_pkg::OP_BGE;
            17'b011010_???????????:   op = id_pkg::OP_BLTU;
            17'b011011_???????????:   op = id_pkg::OP_BGEU;
            default:                  op = id_pkg::OP_INVALID;
        endcase
    end

    always_comb begin
        logic is_reg;
        logic is_cond;
        is_reg  = op inside {[id_pkg::OP_ADD_W:id_pkg::OP_SRA_W]};
        is_cond = op inside {[id_pkg::OP_BEQ:id_pkg::OP_BGEU]};
        src1_is_pc  = op inside {id_pkg::OP_JIRL, id_pkg::OP_BL, id_pkg::OP_PCADDU12I};
        src2_is_imm = !(is_reg || is_cond || op inside {id_pkg::OP_B, id_pkg::OP_INVALID});
        gr_we    = !(is_cond || op inside {id_pkg::OP_ST_W, id_pkg::OP_B, id_pkg::OP_INVALID});
        uses_rj  = !(op inside {id_pkg::OP_B, id_pkg::OP_BL, id_pkg::OP_LU12I_W,
                                id_pkg::OP_PCADDU12I, id_pkg::OP_INVALID});
        uses_rkd = is_reg || is_cond || (op == id_pkg::OP_ST_W);
        raddr2   = (is_cond || op == id_pkg::OP_ST_W) ? rd : rk;
        alu_op   = id_pkg::ALU_ADD;   // addresses, links and pc-relative adds
        mem_op   = id_pkg::MEM_NONE;
        case (op)
            id_pkg::OP_SUB_W:                    alu_op = id_pkg::ALU_SUB;
            id_pkg::OP_SLT, id_pkg::OP_SLTI:     alu_op = id_pkg::ALU_SLT;
            id_pkg::OP_SLTU, id_pkg::OP_SLTUI:   alu_op = id_pkg::ALU_SLTU;
            id_pkg::OP_AND, id_pkg::OP_ANDI:     alu_op = id_pkg::ALU_AND;
            id_pkg::OP_NOR:                      alu_op = id_pkg::ALU_NOR;
            id_pkg::OP_OR, id_pkg::OP_ORI:       alu_op = id_pkg::ALU_OR;
            id_pkg::OP_XOR, id_pkg::OP_XORI:     alu_op = id_pkg::ALU_XOR;
            id_pkg::OP_SLL_W, id_pkg::OP_SLLI_W: alu_op = id_pkg::ALU_SLL;
            id_pkg::OP_SRL_W, id_pkg::OP_SRLI_W: alu_op = id_pkg::ALU_SRL;
            id_pkg::OP_SRA_W, id_pkg::OP_SRAI_W: alu_op = id_pkg::ALU_SRA;
            id_pkg::OP_LU12I_W:                  alu_op = id_pkg::ALU_LUI;
            id_pkg::OP_LD_W:                     mem_op = id_pkg::MEM_LOAD;
            id_pkg::OP_ST_W:                     mem_op = id_pkg::MEM_STORE;
            default: ;
        endcase
    end

    // shift amounts ride in the low bits of the sign-extended form
    assign imm = (op inside {id_pkg::OP_JIRL, id_pkg::OP_BL}) ? id_pkg::XLEN'(4) :
                 (op inside {id_pkg::OP_LU12I_W, id_pkg::OP_PCADDU12I}) ? {i20, 12'b0} :
                 (op inside {id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI}) ?
                     {20'b0, i12} : {{20{i12[11]}}, i12};

    assign br_offs = (op inside {id_pkg::OP_B, id_pkg::OP_BL}) ?
                     {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};

    assign raddr1 = rj;
    assign dest   = (op == id_pkg::OP_BL) ? id_pkg::RA_REG : rd;

endmodule

`default_nettype wire

// File: verilog/id_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module id_regfile (
    input  logic                      clk,
    input  logic [id_pkg::REG_AW-1:0] raddr1,
    input  logic [id_pkg::REG_AW-1:0] raddr2,
    input  logic                      we,
    input  logic [id_pkg::REG_AW-1:0] waddr,
    input  logic [id_pkg::XLEN-1:0]   wdata,
    output logic [id_pkg::XLEN-1:0]   rdata1,
    output logic [id_pkg::XLEN-1:0]   rdata2
);

    logic [id_pkg::XLEN-1:0] regs [id_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 never written, gated on read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: verilog/id_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module id_bypass (
    input  logic [id_pkg::REG_AW-1:0] raddr1,
    input  logic [id_pkg::REG_AW-1:0] raddr2,
    input  logic                      uses_rj,
    input  logic                      uses_rkd,
    input  logic [id_pkg::XLEN-1:0]   rdata1,
    input  logic [id_pkg::XLEN-1:0]   rdata2,
    input  logic                      ex_fwd_valid,
    input  logic                      ex_fwd_we,
    input  logic                      ex_fwd_is_load,
    input  logic [id_pkg::REG_AW-1:0] ex_fwd_addr,
    input  logic [id_pkg::XLEN-1:0]   ex_fwd_result,
    input  logic                      mem_fwd_valid,
    input  logic                      mem_fwd_we,
    input  logic [id_pkg::REG_AW-1:0] mem_fwd_addr,
    input  logic [id_pkg::XLEN-1:0]   mem_fwd_result,
    input  logic                      wb_valid,
    input  logic                      wb_we,
    input  logic [id_pkg::REG_AW-1:0] wb_addr,
    input  logic [id_pkg::XLEN-1:0]   wb_wdata,
    output logic [id_pkg::XLEN-1:0]   rj_value,
    output logic [id_pkg::XLEN-1:0]   rkd_value,
    output logic                      load_use
);

    logic ex_hit1, ex_hit2;
    logic ld_hit1, ld_hit2;
    logic mem_hit1, mem_hit2;
    logic wb_hit1, wb_hit2;

    function automatic logic fwd_hit(input logic                      wr,
                                     input logic [id_pkg::REG_AW-1:0] waddr,
                                     input logic [id_pkg::REG_AW-1:0] raddr);
        return wr && (waddr == raddr) && (raddr != '0);   // r0 never forwards
    endfunction

    assign ex_hit1  = fwd_hit(ex_fwd_valid & ex_fwd_we & ~ex_fwd_is_load, ex_fwd_addr, raddr1);
    assign ex_hit2  = fwd_hit(ex_fwd_valid & ex_fwd_we & ~ex_fwd_is_load, ex_fwd_addr, raddr2);
    assign ld_hit1  = fwd_hit(ex_fwd_valid & ex_fwd_we & ex_fwd_is_load, ex_fwd_addr, raddr1);
    assign ld_hit2  = fwd_hit(ex_fwd_valid & ex_fwd_we & ex_fwd_is_load, ex_fwd_addr, raddr2);
    assign mem_hit1 = fwd_hit(mem_fwd_valid & mem_fwd_we, mem_fwd_addr, raddr1);
    assign mem_hit2 = fwd_hit(mem_fwd_valid & mem_fwd_we, mem_fwd_addr, raddr2);
    assign wb_hit1  = fwd_hit(wb_valid & wb_we, wb_addr, raddr1);
    assign wb_hit2  = fwd_hit(wb_valid & wb_we, wb_addr, raddr2);

    // youngest producer wins
    assign rj_value  = ex_hit1  ? ex_fwd_result  :
                       mem_hit1 ? mem_fwd_result :
                       wb_hit1  ? wb_wdata       : rdata1;
    assign rkd_value = ex_hit2  ? ex_fwd_result  :
                       mem_hit2 ? mem_fwd_result :
                       wb_hit2  ? wb_wdata       : rdata2;

    // load data not ready until memory stage
    assign load_use = (uses_rj && ld_hit1) || (uses_rkd && ld_hit2);

endmodule

`default_nettype wire

// File: verilog/id_branch.sv
`timescale 1ns/10ps
`default_nettype none

module id_branch (
    input  id_pkg::inst_op_t        op,
    input  logic [id_pkg::XLEN-1:0] pc,
    input  logic [id_pkg::XLEN-1:0] rj_value,
    input  logic [id_pkg::XLEN-1:0] rkd_value,
    input  logic [id_pkg::XLEN-1:0] br_offs,
    output logic                    hit,
    output logic [id_pkg::XLEN-1:0] target
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rj_value == rkd_value);
    assign lt_s = ($signed(rj_value) < $signed(rkd_value));
    assign lt_u = (rj_value < rkd_value);

    always_comb begin
        case (op)
            id_pkg::OP_BEQ:  hit = eq;
            id_pkg::OP_BNE:  hit = !eq;
            id_pkg::OP_BLT:  hit = lt_s;
            id_pkg::OP_BGE:  hit = !lt_s;
            id_pkg::OP_BLTU: hit = lt_u;
            id_pkg::OP_BGEU: hit = !lt_u;
            id_pkg::OP_B, id_pkg::OP_BL, id_pkg::OP_JIRL: begin
                hit = 1'b1;   // unconditional
            end
            default: hit = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target = ((op == id_pkg::OP_JIRL) ? rj_value : pc) + br_offs;

endmodule

`default_nettype wire

// File: verilog/id_stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage_reg (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fs_valid,
    input  logic [id_pkg::XLEN-1:0] fs_pc,
    input  logic [id_pkg::XLEN-1:0] fs_inst,
    input  logic                    es_allowin,
    input  logic                    load_use,
    input  logic                    branch_hit,
    output logic                    ds_allowin,
    output logic [id_pkg::XLEN-1:0] ds_pc,
    output logic [id_pkg::XLEN-1:0] ds_inst,
    output logic                    es_valid,
    output logic                    br_taken
);

    logic ds_valid;
    logic ready_go;

    assign ready_go   = !load_use;
    assign ds_allowin = !ds_valid || (ready_go && es_allowin);
    assign es_valid   = ds_valid && ready_go;
    assign br_taken   = ds_valid && branch_hit && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid && !br_taken;   // squash the slot behind a taken branch
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    // held instruction must not move under back-pressure or a stall
    assert property (@(posedge clk) disable iff (reset)
        ds_valid && !ds_allowin |=> $stable(ds_inst) && $stable(ds_pc));

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fs_valid,
    input  logic [id_pkg::XLEN-1:0]   fs_pc,
    input  logic [id_pkg::XLEN-1:0]   fs_inst,
    output logic                      ds_allowin,
    output logic                      es_valid,
    input  logic                      es_allowin,
    output id_pkg::alu_op_t           es_alu_op,
    output logic                      es_src1_is_pc,
    output logic [id_pkg::XLEN-1:0]   es_pc,
    output logic [id_pkg::XLEN-1:0]   es_rj_value,
    output logic                      es_src2_is_imm,
    output logic [id_pkg::XLEN-1:0]   es_imm,
    output logic [id_pkg::XLEN-1:0]   es_rkd_value,
    output logic                      es_gr_we,
    output logic [id_pkg::REG_AW-1:0] es_dest,
    output id_pkg::mem_op_t           es_mem_op,
    output logic                      br_taken,
    output logic [id_pkg::XLEN-1:0]   br_target,
    input  logic                      ex_fwd_valid,
    input  logic                      ex_fwd_we,
    input  logic                      ex_fwd_is_load,
    input  logic [id_pkg::REG_AW-1:0] ex_fwd_addr,
    input  logic [id_pkg::XLEN-1:0]   ex_fwd_result,
    input  logic                      mem_fwd_valid,
    input  logic                      mem_fwd_we,
    input  logic [id_pkg::REG_AW-1:0] mem_fwd_addr,
    input  logic [id_pkg::XLEN-1:0]   mem_fwd_result,
    input  logic                      wb_valid,
    input  logic                      wb_we,
    input  logic [id_pkg::REG_AW-1:0] wb_addr,
    input  logic [id_pkg::XLEN-1:0]   wb_wdata
);

    logic [id_pkg::XLEN-1:0]   ds_inst;
    id_pkg::inst_op_t          op;
    logic [id_pkg::XLEN-1:0]   br_offs;
    logic [id_pkg::REG_AW-1:0] raddr1;
    logic [id_pkg::REG_AW-1:0] raddr2;
    logic                      uses_rj;
    logic                      uses_rkd;
    logic [id_pkg::XLEN-1:0]   rdata1;
    logic [id_pkg::XLEN-1:0]   rdata2;
    logic                      load_use;
    logic                      branch_hit;

    id_stage_reg i_stage_reg (
        .clk(clk), .reset(reset),
        .fs_valid(fs_valid), .fs_pc(fs_pc), .fs_inst(fs_inst),
        .es_allowin(es_allowin), .load_use(load_use), .branch_hit(branch_hit),
        .ds_allowin(ds_allowin), .ds_pc(es_pc), .ds_inst(ds_inst),
        .es_valid(es_valid), .br_taken(br_taken)
    );

    id_decoder i_decoder (
        .inst(ds_inst), .op(op), .alu_op(es_alu_op),
        .src1_is_pc(es_src1_is_pc), .src2_is_imm(es_src2_is_imm), .gr_we(es_gr_we),
        .mem_op(es_mem_op), .imm(es_imm), .br_offs(br_offs),
        .raddr1(raddr1), .raddr2(raddr2), .dest(es_dest),
        .uses_rj(uses_rj), .uses_rkd(uses_rkd)
    );

    id_regfile i_regfile (
        .clk(clk), .raddr1(raddr1), .raddr2(raddr2),
        .we(wb_valid & wb_we), .waddr(wb_addr), .wdata(wb_wdata),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    id_bypass i_bypass (
        .raddr1(raddr1), .raddr2(raddr2), .uses_rj(uses_rj), .uses_rkd(uses_rkd),
        .rdata1(rdata1), .rdata2(rdata2),
        .ex_fwd_valid(ex_fwd_valid), .ex_fwd_we(ex_fwd_we),
        .ex_fwd_is_load(ex_fwd_is_load), .ex_fwd_addr(ex_fwd_addr),
        .ex_fwd_result(ex_fwd_result),
        .mem_fwd_valid(mem_fwd_valid), .mem_fwd_we(mem_fwd_we),
        .mem_fwd_addr(mem_fwd_addr), .mem_fwd_result(mem_fwd_result),
        .wb_valid(wb_valid), .wb_we(wb_we), .wb_addr(wb_addr), .wb_wdata(wb_wdata),
        .rj_value(es_rj_value), .rkd_value(es_rkd_value), .load_use(load_use)
    );

    id_branch i_branch (
        .op(op), .pc(es_pc), .rj_value(es_rj_value), .rkd_value(es_rkd_value),
        .br_offs(br_offs), .hit(branch_hit), .target(br_target)
    );

endmodule

`default_nettype wire

// File: test/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// builds an instruction word, r supplies the immediate bits
function automatic logic [31:0] encode(input id_pkg::inst_op_t op, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk,
                                       input logic [31:0] r);
    logic [4:0] minor;
    logic [3:0] op4;
    logic [5:0] op6;
    minor = 5'b0;
    op4 = 4'b0;
    op6 = 6'b0;
    case (op)
        id_pkg::OP_ADD_W:  minor = 5'b00000;
        id_pkg::OP_SUB_W:  minor = 5'b00010;
        id_pkg::OP_SLT:    minor = 5'b00100;
        id_pkg::OP_SLTU:   minor = 5'b00101;
        id_pkg::OP_NOR:    minor = 5'b01000;
        id_pkg::OP_AND:    minor = 5'b01001;
        id_pkg::OP_OR:     minor = 5'b01010;
        id_pkg::OP_XOR:    minor = 5'b01011;
        id_pkg::OP_SLL_W:  minor = 5'b01110;
        id_pkg::OP_SRL_W:  minor = 5'b01111;
        id_pkg::OP_SRA_W:  minor = 5'b10000;
        id_pkg::OP_SLLI_W: minor = 5'b00001;
        id_pkg::OP_SRLI_W: minor = 5'b01001;
        id_pkg::OP_SRAI_W: minor = 5'b10001;
        id_pkg::OP_SLTI:   op4 = 4'b1000;
        id_pkg::OP_SLTUI:  op4 = 4'b1001;
        id_pkg::OP_ADDI_W: op4 = 4'b1010;
        id_pkg::OP_ANDI:   op4 = 4'b1101;
        id_pkg::OP_ORI:    op4 = 4'b1110;
        id_pkg::OP_XORI:   op4 = 4'b1111;
        id_pkg::OP_JIRL:   op6 = 6'b010011;
        id_pkg::OP_B:      op6 = 6'b010100;
        id_pkg::OP_BL:     op6 = 6'b010101;
        id_pkg::OP_BEQ:    op6 = 6'b010110;
        id_pkg::OP_BNE:    op6 = 6'b010111;
        id_pkg::OP_BLT:    op6 = 6'b011000;
        id_pkg::OP_BGE:    op6 = 6'b011001;
        id_pkg::OP_BLTU:   op6 = 6'b011010;
        id_pkg::OP_BGEU:   op6 = 6'b011011;
        default: ;
    endcase
    if (op <= id_pkg::OP_SRA_W) return {12'b000000_0000_01, minor, rk, rj, rd};
    if (op <= id_pkg::OP_SRAI_W) return {12'b000000_0001_00, minor, rk, rj, rd};
    if (op <= id_pkg::OP_XORI) return {6'b000000, op4, r[11:0], rj, rd};
    if (op == id_pkg::OP_LU12I_W) return {7'b0001010, r[19:0], rd};
    if (op == id_pkg::OP_PCADDU12I) return {7'b0001110, r[19:0], rd};
    if (op == id_pkg::OP_LD_W) return {10'b001010_0010, r[11:0], rj, rd};
    if (op == id_pkg::OP_ST_W) return {10'b001010_0110, r[11:0], rj, rd};
    if (op inside {id_pkg::OP_B, id_pkg::OP_BL}) return {op6, r[15:0], r[25:16]};
    return {op6, r[15:0], rj, rd};
endfunction

function automatic void ref_decode(input id_pkg::inst_op_t op, input logic [31:0] inst,
                                   output id_pkg::alu_op_t alu, output logic [31:0] imm,
                                   output logic [4:0] dest, output logic src1_is_pc,
                                   output logic src2_is_imm, output logic gr_we,
                                   output id_pkg::mem_op_t mem);
    logic is_reg;
    logic is_cond;
    is_reg = op <= id_pkg::OP_SRA_W;
    is_cond = op inside {[id_pkg::OP_BEQ:id_pkg::OP_BGEU]};
    case (op)
        id_pkg::OP_SUB_W: alu = id_pkg::ALU_SUB;
        id_pkg::OP_SLT, id_pkg::OP_SLTI: alu = id_pkg::ALU_SLT;
        id_pkg::OP_SLTU, id_pkg::OP_SLTUI: alu = id_pkg::ALU_SLTU;
        id_pkg::OP_AND, id_pkg::OP_ANDI: alu = id_pkg::ALU_AND;
        id_pkg::OP_NOR: alu = id_pkg::ALU_NOR;
        id_pkg::OP_OR, id_pkg::OP_ORI: alu = id_pkg::ALU_OR;
        id_pkg::OP_XOR, id_pkg::OP_XORI: alu = id_pkg::ALU_XOR;
        id_pkg::OP_SLL_W, id_pkg::OP_SLLI_W: alu = id_pkg::ALU_SLL;
        id_pkg::OP_SRL_W, id_pkg::OP_SRLI_W: alu = id_pkg::ALU_SRL;
        id_pkg::OP_SRA_W, id_pkg::OP_SRAI_W: alu = id_pkg::ALU_SRA;
        id_pkg::OP_LU12I_W: alu = id_pkg::ALU_LUI;
        default: alu = id_pkg::ALU_ADD;
    endcase
    if (op inside {id_pkg::OP_JIRL, id_pkg::OP_BL}) imm = 32'd4;
    else if (op inside {id_pkg::OP_LU12I_W, id_pkg::OP_PCADDU12I}) imm = {inst[24:5], 12'b0};
    else if (op inside {id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI})
        imm = {20'b0, inst[21:10]};
    else imm = {{20{inst[21]}}, inst[21:10]};
    dest = (op == id_pkg::OP_BL) ? id_pkg::RA_REG : inst[4:0];
    src1_is_pc = op inside {id_pkg::OP_JIRL, id_pkg::OP_BL, id_pkg::OP_PCADDU12I};
    src2_is_imm = !(is_reg || is_cond || op == id_pkg::OP_B);
    gr_we = !(is_cond || op inside {id_pkg::OP_ST_W, id_pkg::OP_B});
    mem = (op == id_pkg::OP_LD_W) ? id_pkg::MEM_LOAD :
          (op == id_pkg::OP_ST_W) ? id_pkg::MEM_STORE : id_pkg::MEM_NONE;
endfunction

function automatic void ref_branch(input id_pkg::inst_op_t op, input logic [31:0] pc,
                                   input logic [31:0] a, input logic [31:0] b,
                                   input logic [31:0] inst, output logic taken,
                                   output logic [31:0] target);
    logic [31:0] offs;
    if (op inside {id_pkg::OP_B, id_pkg::OP_BL})
        offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    else
        offs = {{14{inst[25]}}, inst[25:10], 2'b00};
    case (op)
        id_pkg::OP_BEQ:  taken = (a == b);
        id_pkg::OP_BNE:  taken = (a != b);
        id_pkg::OP_BLT:  taken = ($signed(a) < $signed(b));
        id_pkg::OP_BGE:  taken = ($signed(a) >= $signed(b));
        id_pkg::OP_BLTU: taken = (a < b);
        id_pkg::OP_BGEU: taken = (a >= b);
        default:         taken = 1'b1;
    endcase
    target = ((op == id_pkg::OP_JIRL) ? a : pc) + offs;
endfunction

`endif

// File: test/tb_id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage;

    localparam int MAX_CYCLES = 2000;   // about ten times the full run

    logic clk = 1'b0;
    logic reset;
    logic fs_valid, es_allowin, ds_allowin, es_valid, br_taken;
    logic [31:0] fs_pc, fs_inst, es_pc, es_rj_value, es_imm, es_rkd_value, br_target;
    id_pkg::alu_op_t es_alu_op;
    id_pkg::mem_op_t es_mem_op;
    logic es_src1_is_pc, es_src2_is_imm, es_gr_we;
    logic [4:0] es_dest;
    logic ex_fwd_valid, ex_fwd_we, ex_fwd_is_load, mem_fwd_valid, mem_fwd_we, wb_valid, wb_we;
    logic [4:0] ex_fwd_addr, mem_fwd_addr, wb_addr;
    logic [31:0] ex_fwd_result, mem_fwd_result, wb_wdata;
    logic [31:0] shadow [32];
    integer seed;
    int cycles = 0;

    `include "id_ref_model.svh"

    id_stage i_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_alu_op(input string name, input id_pkg::alu_op_t got,
                                input id_pkg::alu_op_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_mem_op(input string name, input id_pkg::mem_op_t got,
                                input id_pkg::mem_op_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // holds fs_valid until the stage takes the word
    task automatic issue(input logic [31:0] inst, input logic [31:0] pc);
        fs_valid = 1'b1;
        fs_inst = inst;
        fs_pc = pc;
        @(negedge clk);
        while (!ds_allowin) @(negedge clk);
        step();
        fs_valid = 1'b0;
    endtask

    task automatic wb_write(input logic [4:0] addr, input logic [31:0] data);
        wb_valid = 1'b1;
        wb_we = 1'b1;
        wb_addr = addr;
        wb_wdata = data;
        step();
        if (addr != 5'd0) shadow[addr] = data;
        wb_valid = 1'b0;
        wb_we = 1'b0;
    endtask

    initial begin
        id_pkg::inst_op_t op;
        id_pkg::alu_op_t exp_alu;
        id_pkg::mem_op_t exp_mem;
        logic [31:0] inst, r, exp_imm, exp_target, pc;
        logic [4:0] rd, rj, rk, exp_dest;
        logic exp_pc, exp_isimm, exp_we, taken;
        seed = 4;
        reset = 1'b1;
        {fs_valid, es_allowin, fs_pc, fs_inst} = '0;
        {ex_fwd_valid, ex_fwd_we, ex_fwd_is_load, ex_fwd_addr, ex_fwd_result} = '0;
        {mem_fwd_valid, mem_fwd_we, mem_fwd_addr, mem_fwd_result} = '0;
        {wb_valid, wb_we, wb_addr, wb_wdata} = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        es_allowin = 1'b1;
        @(negedge clk);
        check_bit("ds_allowin", ds_allowin, 1'b1);
        check_bit("es_valid", es_valid, 1'b0);
        check_bit("br_taken", br_taken, 1'b0);
        step();

        // register file through the writeback port
        for (int i = 0; i < 32; i++) wb_write(5'(i), $random(seed));
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            rj = (i == 0) ? 5'd0 : r[4:0];
            rk = r[9:5];
            issue(encode(id_pkg::OP_ADD_W, 5'd2, rj, rk, 32'd0), 32'h100);
            @(negedge clk);
            check_word("es_rj_value", es_rj_value, shadow[rj]);
            check_word("es_rkd_value", es_rkd_value, shadow[rk]);
            step();
        end

        // decode of every kept instruction
        for (int k = 0; k <= int'(id_pkg::OP_JIRL); k++) begin
            op = id_pkg::inst_op_t'(k);
            r = $random(seed);
            inst = encode(op, r[4:0], r[9:5], r[14:10], $random(seed));
            issue(inst, {r[31:2], 2'b00});
            @(negedge clk);
            while (!es_valid) @(negedge clk);
            ref_decode(op, inst, exp_alu, exp_imm, exp_dest, exp_pc, exp_isimm, exp_we, exp_mem);
            check_alu_op("es_alu_op", es_alu_op, exp_alu);
            check_word("es_imm", es_imm, exp_imm);
            check_reg("es_dest", es_dest, exp_dest);
            check_bit("es_src1_is_pc", es_src1_is_pc, exp_pc);
            check_bit("es_src2_is_imm", es_src2_is_imm, exp_isimm);
            check_bit("es_gr_we", es_gr_we, exp_we);
            check_mem_op("es_mem_op", es_mem_op, exp_mem);
            check_word("es_pc", es_pc, {r[31:2], 2'b00});
            step();
        end

        // forwarding priority under back-pressure
        es_allowin = 1'b0;
        issue(encode(id_pkg::OP_ADD_W, 5'd3, 5'd5, 5'd6, 32'd0), 32'h200);
        {ex_fwd_valid, ex_fwd_we, ex_fwd_addr, ex_fwd_result} = {2'b11, 5'd5, 32'h1111_aaaa};
        {mem_fwd_valid, mem_fwd_we, mem_fwd_addr, mem_fwd_result} = {2'b11, 5'd5, 32'h2222_bbbb};
        {wb_valid, wb_we, wb_addr, wb_wdata} = {2'b11, 5'd5, 32'h3333_cccc};
        @(negedge clk);
        check_word("es_rj_value", es_rj_value, 32'h1111_aaaa);
        step();
        ex_fwd_valid = 1'b0;
        @(negedge clk);
        check_word("es_rj_value", es_rj_value, 32'h2222_bbbb);
        step();
        mem_fwd_valid = 1'b0;
        wb_wdata = 32'h4444_dddd;   // file still holds the older write
        @(negedge clk);
        check_word("es_rj_value", es_rj_value, 32'h4444_dddd);
        step();
        shadow[5] = 32'h4444_dddd;   // the writeback also landed in the file
        {wb_valid, wb_we, mem_fwd_we, ex_fwd_we} = '0;
        es_allowin = 1'b1;
        step();

        // load-use stall
        {ex_fwd_valid, ex_fwd_we, ex_fwd_is_load, ex_fwd_addr} = {3'b111, 5'd7};
        issue(encode(id_pkg::OP_ADD_W, 5'd3, 5'd7, 5'd8, 32'd0), 32'h300);
        repeat (3) begin
            @(negedge clk);
            check_bit("es_valid", es_valid, 1'b0);
            check_bit("ds_allowin", ds_allowin, 1'b0);
            step();
        end
        {ex_fwd_valid, ex_fwd_we, ex_fwd_is_load} = '0;
        {mem_fwd_valid, mem_fwd_we, mem_fwd_addr, mem_fwd_result} = {2'b11, 5'd7, 32'h0bad_f00d};
        @(negedge clk);
        check_bit("es_valid", es_valid, 1'b1);
        check_word("es_rj_value", es_rj_value, 32'h0bad_f00d);
        step();
        {mem_fwd_valid, mem_fwd_we} = '0;

        // branches with a fetch right behind each one
        for (int k = int'(id_pkg::OP_BEQ); k <= int'(id_pkg::OP_JIRL); k++) begin
            for (int t = 0; t < 2; t++) begin
                op = id_pkg::inst_op_t'(k);
                r = $random(seed);
                rj = r[4:0];
                rd = (t == 0) ? rj : r[9:5];
                pc = {$random(seed)} & 32'hffff_fffc;
                inst = encode(op, rd, rj, 5'd0, $random(seed));
                ref_branch(op, pc, shadow[rj], shadow[rd], inst, taken, exp_target);
                issue(inst, pc);
                fs_valid = 1'b1;
                fs_inst = encode(id_pkg::OP_ADD_W, 5'd4, 5'd1, 5'd2, 32'd0);
                fs_pc = pc + 32'd4;
                @(negedge clk);
                check_bit("br_taken", br_taken, taken);
                check_word("br_target", br_target, exp_target);
                step();
                fs_valid = 1'b0;
                @(negedge clk);
                check_bit("es_valid", es_valid, !taken);
                step();
            end
        end

        // back-pressure holds the bundle
        es_allowin = 1'b0;
        issue(encode(id_pkg::OP_ORI, 5'd9, 5'd1, 5'd0, 32'h0a5), 32'h400);
        fs_valid = 1'b1;
        fs_inst = encode(id_pkg::OP_XORI, 5'd10, 5'd1, 5'd0, 32'h35a);
        fs_pc = 32'h404;
        repeat (4) begin
            @(negedge clk);
            check_bit("ds_allowin", ds_allowin, 1'b0);
            check_bit("es_valid", es_valid, 1'b1);
            check_word("es_imm", es_imm, 32'h0a5);
            check_reg("es_dest", es_dest, 5'd9);
            step();
        end
        es_allowin = 1'b1;
        @(negedge clk);
        check_bit("es_valid", es_valid, 1'b1);
        step();
        fs_valid = 1'b0;
        es_allowin = 1'b0;
        @(negedge clk);
        check_word("es_imm", es_imm, 32'h35a);   // second one now held
        check_reg("es_dest", es_dest, 5'd10);
        es_allowin = 1'b1;
        step();
        @(negedge clk);
        check_bit("es_valid", es_valid, 1'b0);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+test
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_regfile.sv
verilog/id_bypass.sv
verilog/id_branch.sv
verilog/id_stage_reg.sv
verilog/id_stage.sv
test/tb_id_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_id_stage \
    --Mdir obj_dir -o sim_tb_id_stage
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb_id_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1
